/* hw/l2CachePkg.sv */
/*
  Shared definitions for the L2 tag and state cache.
  Address layout, address union, command, MESI, snoop and bus types.
*/

package l2CachePkg;

  // ******************************
  // Address layout
  // ******************************
  localparam int AddrWidth  = 32;
  localparam int OffsetBits = 6;
  localparam int IndexBits  = 4;
  localparam int TagBits    = AddrWidth - IndexBits - OffsetBits;
  localparam int NumSets    = 2 ** IndexBits;

  // Tag in the upper bits, byte select at the bottom
  typedef struct packed {
    logic [TagBits-1:0]    tag;
    logic [IndexBits-1:0]  index;
    logic [OffsetBits-1:0] offset;
  } addrFieldsT;

  // Same address word, flat or split into fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addrFieldsT           fields;
  } cacheAddrU;

  // ******************************
  // Encodings
  // ******************************
  typedef enum logic [1:0] {DataRead, DataWrite, InstrRead, Clear} l1CmdT;
  typedef enum logic [1:0] {SnoopRead, SnoopRwim, SnoopInval} snoopCmdT;
  typedef enum logic [1:0] {Invalid, Shared, Exclusive, Modified} mesiT;
  typedef enum logic [1:0] {Miss, Hit, HitM} snoopResT;
  typedef enum logic [1:0] {BusNone, BusRead, BusRwim, BusInval} busOpT;

  // Request and response words
  typedef struct packed {
    l1CmdT                cmd;
    logic [AddrWidth-1:0] addr;
  } l1ReqT;

  typedef struct packed {
    snoopCmdT             cmd;
    logic [AddrWidth-1:0] addr;
  } snoopReqT;

  typedef struct packed {
    busOpT                op;
    logic [AddrWidth-1:0] addr;
  } busOutT;

  // Write-back of a Modified victim
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
  } evictT;

  // One way of one set
  typedef struct packed {
    logic [TagBits-1:0] tag;
    mesiT               mesi;
  } wayEntryT;

endpackage

/* hw/tagStateArray.sv */
/*
  Tag and MESI storage for every set and way.
  Combinational read of one set, single-way write, bulk invalidate.
*/

module tagStateArray #(
  parameter  int NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic [l2CachePkg::IndexBits-1:0]     rdIndex,
  output l2CachePkg::wayEntryT [NumWays-1:0]   setEntries,
  input  logic                                 wrEn,
  input  logic [l2CachePkg::IndexBits-1:0]     wrIndex,
  input  logic [WayBits-1:0]                   wrWay,
  input  l2CachePkg::wayEntryT                 wrEntry,
  input  logic                                 clear
);
  import l2CachePkg::*;

  // Storage indexed by set, then way
  wayEntryT entries [NumSets][NumWays];

  // ******************************
  // Read side
  // ******************************
  // Whole addressed set goes out at once
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      setEntries[w] = entries[rdIndex][w];
    end
  end

  // ******************************
  // Write side
  // ******************************
  // Reset and clear mark every way Invalid
  always_ff @(posedge clk) begin
    if (!rstN || clear) begin
      for (int s = 0; s < NumSets; s++) begin
        for (int w = 0; w < NumWays; w++) begin
          entries[s][w].mesi <= Invalid;
        end
      end
    end else if (wrEn) begin
      // One way takes the new tag and state
      entries[wrIndex][wrWay] <= wrEntry;
    end
  end

endmodule

/* hw/wayLookup.sv */
/*
  Tag comparators, hit encoder and free-way finder for one set.
*/

module wayLookup #(
  parameter  int NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  l2CachePkg::wayEntryT [NumWays-1:0] setEntries,
  input  logic [l2CachePkg::TagBits-1:0]     tag,
  output logic                               hit,
  output logic [WayBits-1:0]                 hitWay,
  output logic                               freeValid,
  output logic [WayBits-1:0]                 freeWay
);
  import l2CachePkg::*;

  logic [NumWays-1:0] match;

  // One comparator per way, Invalid ways never match
  for (genvar w = 0; w < NumWays; w++) begin : genCompare
    assign match[w] = (setEntries[w].mesi != Invalid) && (setEntries[w].tag == tag);
  end

  assign hit = |match;

  // Encoder
  // At most one way matches in a consistent set
  always_comb begin
    hitWay = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (match[w]) hitWay = WayBits'(w);
    end
  end

  // Priority finder, scan from the top so way 0 wins
  always_comb begin
    freeValid = 1'b0;
    freeWay   = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (setEntries[w].mesi == Invalid) begin
        freeValid = 1'b1;
        freeWay   = WayBits'(w);
      end
    end
  end

endmodule

/* hw/lruPolicy.sv */
/*
  Per-set LRU ages, oldest-way select and age update on access.
  Ages in a set are a permutation, 0 being most recent.
*/

module lruPolicy #(
  parameter  int NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [l2CachePkg::IndexBits-1:0] index,
  output logic [WayBits-1:0]               oldestWay,
  input  logic                             touch,
  input  logic [WayBits-1:0]               touchWay,
  input  logic                             clear
);
  import l2CachePkg::*;

  logic [WayBits-1:0] ages [NumSets][NumWays];

  // ******************************
  // Victim candidate
  // ******************************
  // Largest age is NumWays-1 in a permutation
  always_comb begin
    oldestWay = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (ages[index][w] == WayBits'(NumWays - 1)) oldestWay = WayBits'(w);
    end
  end

  // ******************************
  // Age update
  // ******************************
  always_ff @(posedge clk) begin
    if (!rstN || clear) begin
      // Way w starts with age w
      for (int s = 0; s < NumSets; s++) begin
        for (int w = 0; w < NumWays; w++) begin
          ages[s][w] <= WayBits'(w);
        end
      end
    end else if (touch) begin
      // Younger ways shift up by one
      for (int w = 0; w < NumWays; w++) begin
        if (ages[index][w] < ages[index][touchWay]) begin
          ages[index][w] <= ages[index][w] + 1'b1;
        end
      end
      // Touched way becomes most recent
      ages[index][touchWay] <= '0;
    end
  end

endmodule

/* hw/coherenceController.sv */
/*
  L1 and snoop request handling for the L2 tags.
  Handshake FSM, victim choice, MESI transitions, bus and eviction outputs.
*/

module coherenceController #(
  parameter  int NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               l1Req,
  input  l2CachePkg::l1ReqT                  l1Cmd,
  output logic                               l1Ack,
  input  logic                               snoopReq,
  input  l2CachePkg::snoopReqT               snoopCmd,
  output logic                               snoopAck,
  input  l2CachePkg::snoopResT               snoopResIn,
  output l2CachePkg::snoopResT               snoopRes,
  output l2CachePkg::busOutT                 busOut,
  output l2CachePkg::evictT                  evict,
  // Storage side
  output logic [l2CachePkg::IndexBits-1:0]   index,
  output logic [l2CachePkg::TagBits-1:0]     tag,
  input  l2CachePkg::wayEntryT [NumWays-1:0] setEntries,
  input  logic                               hit,
  input  logic [WayBits-1:0]                 hitWay,
  input  logic                               freeValid,
  input  logic [WayBits-1:0]                 freeWay,
  input  logic [WayBits-1:0]                 oldestWay,
  output logic                               wrEn,
  output logic [WayBits-1:0]                 wrWay,
  output l2CachePkg::wayEntryT               wrEntry,
  output logic                               touch,
  output logic [WayBits-1:0]                 touchWay,
  output logic                               clear,
  // Statistics
  output logic                               readPulse,
  output logic                               writePulse,
  output logic                               hitPulse,
  output logic                               missPulse
);
  import l2CachePkg::*;

  typedef enum logic [1:0] {Idle, Lookup, Update} stateT;

  stateT              state;
  logic               acceptSnoop;
  logic               acceptL1;
  // Transaction registers
  logic               isSnoopQ;
  l1CmdT              l1CmdQ;
  snoopCmdT           snoopCmdQ;
  cacheAddrU          addrQ;
  logic               hitQ;
  logic [WayBits-1:0] wayQ;
  wayEntryT           victimQ;
  logic [WayBits-1:0] pickWay;
  // Decoded update
  logic               isAccess;
  logic               evictD;
  busOpT              busOpD;
  snoopResT           snoopResD;
  wayEntryT           newEntry;
  cacheAddrU          evictAddr;
  // Output registers
  busOpT                busOpQ;
  logic [AddrWidth-1:0] busAddrQ;
  logic                 evictValidQ;
  logic [AddrWidth-1:0] evictAddrQ;

  // ******************************
  // Arbitration
  // ******************************
  // Nothing new while either ack is still up, snoop wins a tie
  assign acceptSnoop = (state == Idle) && !l1Ack && !snoopAck && snoopReq;
  assign acceptL1    = (state == Idle) && !l1Ack && !snoopAck && !snoopReq && l1Req;

  // Storage is addressed from the registered request
  assign index = addrQ.fields.index;
  assign tag   = addrQ.fields.tag;

  // Hit way, else first free way, else LRU way
  assign pickWay = hit ? hitWay : (freeValid ? freeWay : oldestWay);

  always_ff @(posedge clk) begin
    if (acceptSnoop) begin
      isSnoopQ  <= 1'b1;
      snoopCmdQ <= snoopCmd.cmd;
      addrQ.raw <= snoopCmd.addr;
    end else if (acceptL1) begin
      isSnoopQ  <= 1'b0;
      l1CmdQ    <= l1Cmd.cmd;
      addrQ.raw <= l1Cmd.addr;
    end
    if (state == Lookup) begin
      hitQ    <= hit;
      wayQ    <= pickWay;
      victimQ <= setEntries[pickWay];
    end
    if (state == Update) begin
      busAddrQ   <= addrQ.raw;
      evictAddrQ <= evictAddr.raw;
    end
  end

  // ******************************
  // MESI transitions
  // ******************************
  // Clear goes through the FSM but touches nothing here
  assign isAccess = !isSnoopQ && (l1CmdQ != Clear);

  always_comb begin
    newEntry.tag  = addrQ.fields.tag;
    newEntry.mesi = victimQ.mesi;
    busOpD        = BusNone;
    snoopResD     = Miss;
    if (isSnoopQ) begin
      if (hitQ) begin
        snoopResD     = (victimQ.mesi == Modified) ? HitM : Hit;
        // Read keeps a copy, RWIM and invalidate drop it
        newEntry.mesi = (snoopCmdQ == SnoopRead) ? Shared : Invalid;
      end
    end else if (l1CmdQ == DataWrite) begin
      newEntry.mesi = Modified;
      if (!hitQ) busOpD = BusRwim;
      else if (victimQ.mesi == Shared) busOpD = BusInval;
    end else if (isAccess && !hitQ) begin
      busOpD = BusRead;
      // Another holder answered, so the fill is shared
      newEntry.mesi = (snoopResIn != Miss) ? Shared : Exclusive;
    end
  end

  // Dirty victim leaves on any L1 miss
  assign evictD = isAccess && !hitQ && (victimQ.mesi == Modified);

  // Line address of the victim, offset zero
  assign evictAddr.fields = '{tag: victimQ.tag, index: addrQ.fields.index, offset: '0};

  // ******************************
  // Strobes, all in UPDATE only
  // ******************************
  assign wrEn       = (state == Update) && (isAccess || (isSnoopQ && hitQ));
  assign wrWay      = wayQ;
  assign wrEntry    = newEntry;
  assign touch      = (state == Update) && isAccess;
  assign touchWay   = wayQ;
  assign clear      = (state == Update) && !isSnoopQ && (l1CmdQ == Clear);
  assign readPulse  = touch && (l1CmdQ != DataWrite);
  assign writePulse = touch && (l1CmdQ == DataWrite);
  assign hitPulse   = touch && hitQ;
  assign missPulse  = touch && !hitQ;

  // ******************************
  // FSM and handshake
  // ******************************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= Idle;
      l1Ack       <= 1'b0;
      snoopAck    <= 1'b0;
      busOpQ      <= BusNone;
      evictValidQ <= 1'b0;
      snoopRes    <= Miss;
    end else begin
      case (state)
        Idle: begin
          // Ack falls once its req is seen low
          if (snoopAck && !snoopReq) begin
            snoopAck <= 1'b0;
            snoopRes <= Miss;
          end
          if (l1Ack && !l1Req) begin
            l1Ack       <= 1'b0;
            busOpQ      <= BusNone;
            evictValidQ <= 1'b0;
          end
          if (acceptSnoop || acceptL1) state <= Lookup;
        end
        Lookup: state <= Update;
        Update: begin
          if (isSnoopQ) begin
            snoopAck <= 1'b1;
            snoopRes <= snoopResD;
          end else begin
            l1Ack       <= 1'b1;
            busOpQ      <= busOpD;
            evictValidQ <= evictD;
          end
          state <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  assign busOut = '{op: busOpQ, addr: busAddrQ};
  assign evict  = '{valid: evictValidQ, addr: evictAddrQ};

endmodule

/* hw/statCounters.sv */
/*
  Hit, miss, read and write statistics counters.
*/

module statCounters (
  input  logic        clk,
  input  logic        rstN,
  input  logic        readPulse,
  input  logic        writePulse,
  input  logic        hitPulse,
  input  logic        missPulse,
  output logic [31:0] hits,
  output logic [31:0] misses,
  output logic [31:0] reads,
  output logic [31:0] writes
);

  // Plain wrap-around counters, one pulse per access
  always_ff @(posedge clk) begin
    if (!rstN) begin
      hits   <= '0;
      misses <= '0;
      reads  <= '0;
      writes <= '0;
    end else begin
      if (hitPulse)   hits   <= hits + 1'b1;
      if (missPulse)  misses <= misses + 1'b1;
      if (readPulse)  reads  <= reads + 1'b1;
      if (writePulse) writes <= writes + 1'b1;
    end
  end

endmodule

/* hw/l2CacheTop.sv */
/*
  L2 cache tag and state top level.
  Controller, tag array, lookup, LRU and statistics.
*/

module l2CacheTop #(
  parameter  int NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 l1Req,
  input  l2CachePkg::l1ReqT    l1Cmd,
  output logic                 l1Ack,
  input  logic                 snoopReq,
  input  l2CachePkg::snoopReqT snoopCmd,
  output logic                 snoopAck,
  input  l2CachePkg::snoopResT snoopResIn,
  output l2CachePkg::snoopResT snoopRes,
  output l2CachePkg::busOutT   busOut,
  output l2CachePkg::evictT    evict,
  output logic [31:0]          hits,
  output logic [31:0]          misses,
  output logic [31:0]          reads,
  output logic [31:0]          writes
);
  import l2CachePkg::*;

  // Storage interface
  logic [IndexBits-1:0]    index;
  logic [TagBits-1:0]      tag;
  wayEntryT [NumWays-1:0]  setEntries;
  logic                    hit;
  logic                    freeValid;
  logic [WayBits-1:0]      hitWay;
  logic [WayBits-1:0]      freeWay;
  logic [WayBits-1:0]      oldestWay;
  logic                    wrEn;
  logic [WayBits-1:0]      wrWay;
  wayEntryT                wrEntry;
  logic                    touch;
  logic [WayBits-1:0]      touchWay;
  logic                    clear;
  // Statistics pulses
  logic readPulse;
  logic writePulse;
  logic hitPulse;
  logic missPulse;

  coherenceController #(.NumWays(NumWays)) u_ctrl (
    .clk, .rstN, .l1Req, .l1Cmd, .l1Ack, .snoopReq, .snoopCmd, .snoopAck,
    .snoopResIn, .snoopRes, .busOut, .evict, .index, .tag, .setEntries,
    .hit, .hitWay, .freeValid, .freeWay, .oldestWay, .wrEn, .wrWay, .wrEntry,
    .touch, .touchWay, .clear, .readPulse, .writePulse, .hitPulse, .missPulse
  );

  // Read and write share the registered index
  tagStateArray #(.NumWays(NumWays)) u_tags (
    .clk, .rstN, .rdIndex(index), .setEntries, .wrEn, .wrIndex(index),
    .wrWay, .wrEntry, .clear
  );

  wayLookup #(.NumWays(NumWays)) u_lookup (
    .setEntries, .tag, .hit, .hitWay, .freeValid, .freeWay
  );

  lruPolicy #(.NumWays(NumWays)) u_lru (
    .clk, .rstN, .index, .oldestWay, .touch, .touchWay, .clear
  );

  statCounters u_stats (
    .clk, .rstN, .readPulse, .writePulse, .hitPulse, .missPulse,
    .hits, .misses, .reads, .writes
  );

endmodule

/* bench/l2CacheModel.svh */
/*
  Reference model of the L2 tags, MESI states, LRU ages and counters.
  Included inside the testbench module, uses its NumWays.
*/

`ifndef L2CACHEMODEL_SVH
`define L2CACHEMODEL_SVH

// ******************************
// Model state
// ******************************
logic [TagBits-1:0] mTag [NumSets][NumWays];
mesiT               mMesi [NumSets][NumWays];
int                 mAge [NumSets][NumWays];
int                 mHits;
int                 mMisses;
int                 mReads;
int                 mWrites;

// Expected outputs of the last transaction
busOpT       expBusOp;
logic [31:0] expBusAddr;
logic        expEvictValid;
logic [31:0] expEvictAddr;
snoopResT    expSnoopRes;

// Power-up and Clear both land here, way w gets age w
task automatic resetLines();
  for (int s = 0; s < NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      mTag[s][w]  = '0;
      mMesi[s][w] = Invalid;
      mAge[s][w]  = w;
    end
  end
endtask

// Way holding a valid copy of the tag, -1 if none
function automatic int findHit(int set, logic [TagBits-1:0] tag);
  int way;
  way = -1;
  for (int w = 0; w < NumWays; w++) begin
    if (way < 0 && mMesi[set][w] != Invalid && mTag[set][w] == tag) way = w;
  end
  return way;
endfunction

// Lowest Invalid way first, otherwise the oldest one
function automatic int pickVictim(int set);
  int way;
  way = -1;
  for (int w = 0; w < NumWays; w++) begin
    if (way < 0 && mMesi[set][w] == Invalid) way = w;
  end
  if (way < 0) begin
    for (int w = 0; w < NumWays; w++) begin
      if (mAge[set][w] == NumWays - 1) way = w;
    end
  end
  return way;
endfunction

// Accessed way becomes age 0, everything younger ages by one
task automatic makeYoungest(int set, int way);
  int old;
  old = mAge[set][way];
  for (int w = 0; w < NumWays; w++) begin
    if (mAge[set][w] < old) mAge[set][w] = mAge[set][w] + 1;
  end
  mAge[set][way] = 0;
endtask

// ******************************
// Transactions
// ******************************
task automatic modelL1(l1CmdT cmd, logic [31:0] addr, snoopResT others);
  int                 set;
  int                 way;
  logic               hitNow;
  logic [TagBits-1:0] tag;
  set           = addr[OffsetBits +: IndexBits];
  tag           = addr[31 -: TagBits];
  expBusOp      = BusNone;
  expBusAddr    = addr;
  expEvictValid = 1'b0;
  expEvictAddr  = '0;
  if (cmd == Clear) begin
    resetLines();
  end else begin
    way    = findHit(set, tag);
    hitNow = (way >= 0);
    if (!hitNow) begin
      way = pickVictim(set);
      // Dirty victim is written back as a line address
      if (mMesi[set][way] == Modified) begin
        expEvictValid = 1'b1;
        expEvictAddr  = {mTag[set][way], IndexBits'(set), OffsetBits'(0)};
      end
    end
    if (cmd == DataWrite) begin
      if (!hitNow) expBusOp = BusRwim;
      else if (mMesi[set][way] == Shared) expBusOp = BusInval;
      mMesi[set][way] = Modified;
      mWrites++;
    end else begin
      if (!hitNow) begin
        expBusOp        = BusRead;
        mMesi[set][way] = (others != Miss) ? Shared : Exclusive;
      end
      mReads++;
    end
    mTag[set][way] = tag;
    if (hitNow) mHits++;
    else mMisses++;
    makeYoungest(set, way);
  end
endtask

// Snoops leave ages and counters alone
task automatic modelSnoop(snoopCmdT cmd, logic [31:0] addr);
  int set;
  int way;
  set = addr[OffsetBits +: IndexBits];
  way = findHit(set, addr[31 -: TagBits]);
  if (way < 0) begin
    expSnoopRes = Miss;
  end else begin
    expSnoopRes     = (mMesi[set][way] == Modified) ? HitM : Hit;
    mMesi[set][way] = (cmd == SnoopRead) ? Shared : Invalid;
  end
endtask

`endif

/* bench/l2CacheTb.sv */
/*
  Testbench for the L2 tag and state cache.
  Random L1 and snoop traffic, four-phase handshakes, model checks, timeout.
*/

module l2CacheTb;
  import l2CachePkg::*;

  localparam int NumWays    = 4;
  localparam int NumTrans   = 600;
  localparam int CycleLimit = NumTrans * 10;
  localparam int AckLatency = 2;
  localparam int AckWaitMax = 16;

  logic        clk;
  logic        rstN;
  logic        l1Req;
  l1ReqT       l1Cmd;
  logic        l1Ack;
  logic        snoopReq;
  snoopReqT    snoopCmd;
  logic        snoopAck;
  snoopResT    snoopResIn;
  snoopResT    snoopRes;
  busOutT      busOut;
  evictT       evict;
  logic [31:0] hits;
  logic [31:0] misses;
  logic [31:0] reads;
  logic [31:0] writes;

  integer seed;
  int     valueErrors;
  int     handshakeErrors;
  int     cycles;

  `include "l2CacheModel.svh"

  l2CacheTop #(.NumWays(NumWays)) u_dut (
    .clk, .rstN, .l1Req, .l1Cmd, .l1Ack, .snoopReq, .snoopCmd, .snoopAck,
    .snoopResIn, .snoopRes, .busOut, .evict, .hits, .misses, .reads, .writes
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ******************************
  // Helpers
  // ******************************
  function automatic int pickBelow(int n);
    return {$random(seed)} % n;
  endfunction

  // 6 tags over 4 sets keeps sets full and lines resident
  function automatic logic [31:0] makeAddr();
    logic [TagBits-1:0]    tag;
    logic [IndexBits-1:0]  set;
    logic [OffsetBits-1:0] offset;
    tag    = TagBits'(pickBelow(6)) * 22'h1f0f1 + 22'h15;
    set    = IndexBits'(pickBelow(4) * 5);
    offset = OffsetBits'(pickBelow(64));
    return {tag, set, offset};
  endfunction

  task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
    valueErrors++;
    $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
  endtask

  // Counts falling edges until ack, latency is cycles after the sampling edge
  task automatic waitAckHigh(input bit forSnoop, output int latency);
    int n;
    n       = 0;
    latency = -1;
    while (n < AckWaitMax && latency < 0) begin
      @(negedge clk);
      n++;
      if ((forSnoop ? snoopAck : l1Ack) === 1'b1) latency = n - 1;
    end
    if (latency < 0) begin
      handshakeErrors++;
      $display("At %0t the %s ack never rose within %0d cycles", $time,
               forSnoop ? "snoop" : "L1", AckWaitMax);
    end else if (latency != AckLatency) begin
      handshakeErrors++;
      $display("At %0t the %s ack rose %0d cycles after the request, not %0d",
               $time, forSnoop ? "snoop" : "L1", latency, AckLatency);
    end
  endtask

  // Req drops on this falling edge, ack must be low by the next one
  task automatic dropAndWait(input bit forSnoop);
    int n;
    if (forSnoop) snoopReq = 1'b0;
    else l1Req = 1'b0;
    @(negedge clk);
    n = 1;
    if ((forSnoop ? snoopAck : l1Ack) !== 1'b0) begin
      handshakeErrors++;
      $display("At %0t the %s ack stayed high a cycle after its request dropped",
               $time, forSnoop ? "snoop" : "L1");
      while (n < AckWaitMax && (forSnoop ? snoopAck : l1Ack) !== 1'b0) begin
        @(negedge clk);
        n++;
      end
    end
    // Outputs return to idle values with the ack
    if (!forSnoop && l1Ack === 1'b0) begin
      if (busOut.op !== BusNone) reportMismatch("busOut.op idle", BusNone, busOut.op);
      if (evict.valid !== 1'b0) reportMismatch("evict.valid idle", 1'b0, evict.valid);
    end
    if (forSnoop && snoopAck === 1'b0) begin
      if (snoopRes !== Miss) reportMismatch("snoopRes idle", Miss, snoopRes);
    end
  endtask

  // ******************************
  // Output checks
  // ******************************
  task automatic checkCounters();
    if (hits !== 32'(mHits)) reportMismatch("hits", mHits, hits);
    if (misses !== 32'(mMisses)) reportMismatch("misses", mMisses, misses);
    if (reads !== 32'(mReads)) reportMismatch("reads", mReads, reads);
    if (writes !== 32'(mWrites)) reportMismatch("writes", mWrites, writes);
  endtask

  task automatic checkL1Outputs();
    if (busOut.op !== expBusOp) reportMismatch("busOut.op", expBusOp, busOut.op);
    if (expBusOp != BusNone && busOut.addr !== expBusAddr) begin
      reportMismatch("busOut.addr", expBusAddr, busOut.addr);
    end
    if (evict.valid !== expEvictValid) reportMismatch("evict.valid", expEvictValid, evict.valid);
    if (expEvictValid && evict.addr !== expEvictAddr) begin
      reportMismatch("evict.addr", expEvictAddr, evict.addr);
    end
    checkCounters();
  endtask

  task automatic checkSnoopOutputs();
    if (snoopRes !== expSnoopRes) reportMismatch("snoopRes", expSnoopRes, snoopRes);
    checkCounters();
  endtask

  // ******************************
  // Transactions
  // ******************************
  // All of them start and end on a falling edge
  task automatic runL1(l1CmdT cmd, logic [31:0] addr, snoopResT others);
    int lat;
    l1Cmd      = '{cmd: cmd, addr: addr};
    snoopResIn = others;
    l1Req      = 1'b1;
    modelL1(cmd, addr, others);
    waitAckHigh(1'b0, lat);
    if (lat >= 0) checkL1Outputs();
    dropAndWait(1'b0);
  endtask

  task automatic runSnoop(snoopCmdT cmd, logic [31:0] addr);
    int lat;
    snoopCmd = '{cmd: cmd, addr: addr};
    snoopReq = 1'b1;
    modelSnoop(cmd, addr);
    waitAckHigh(1'b1, lat);
    if (lat >= 0) checkSnoopOutputs();
    dropAndWait(1'b1);
  endtask

  // Both requests raised together, snoop goes first
  task automatic runPair(l1CmdT cmd, logic [31:0] addr, snoopResT others,
                         snoopCmdT sCmd, logic [31:0] sAddr);
    int lat;
    l1Cmd      = '{cmd: cmd, addr: addr};
    snoopResIn = others;
    snoopCmd   = '{cmd: sCmd, addr: sAddr};
    l1Req      = 1'b1;
    snoopReq   = 1'b1;
    modelSnoop(sCmd, sAddr);
    waitAckHigh(1'b1, lat);
    if (lat >= 0) begin
      if (l1Ack !== 1'b0) begin
        handshakeErrors++;
        $display("At %0t the L1 ack rose while the snoop was being served", $time);
      end
      checkSnoopOutputs();
    end
    dropAndWait(1'b1);
    // L1 request is still pending and is taken on the next edge
    modelL1(cmd, addr, others);
    waitAckHigh(1'b0, lat);
    if (lat >= 0) checkL1Outputs();
    dropAndWait(1'b0);
  endtask

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    int          done;
    int          r;
    l1CmdT       cmd;
    logic [31:0] addr;
    snoopResT    others;
    seed            = 32'hbb86_ebfe;
    valueErrors     = 0;
    handshakeErrors = 0;
    rstN            = 1'b0;
    l1Req           = 1'b0;
    l1Cmd           = '0;
    snoopReq        = 1'b0;
    snoopCmd        = '0;
    snoopResIn      = Miss;
    mHits           = 0;
    mMisses         = 0;
    mReads          = 0;
    mWrites         = 0;
    resetLines();
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    checkCounters();
    done = 0;
    while (done < NumTrans) begin
      if (pickBelow(10) < 7) begin
        r = pickBelow(100);
        if (r < 2) cmd = Clear;
        else if (r < 45) cmd = DataRead;
        else if (r < 80) cmd = DataWrite;
        else cmd = InstrRead;
        addr   = makeAddr();
        others = snoopResT'(pickBelow(3));
        // Some L1 requests arrive together with a snoop
        if (pickBelow(10) == 0) begin
          runPair(cmd, addr, others, snoopCmdT'(pickBelow(3)), makeAddr());
          done = done + 2;
        end else begin
          runL1(cmd, addr, others);
          done++;
        end
      end else begin
        runSnoop(snoopCmdT'(pickBelow(3)), makeAddr());
        done++;
      end
    end
    $display("Error counts: value %0d, handshake %0d", valueErrors, handshakeErrors);
    if (valueErrors + handshakeErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog over the whole run
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped at the limit of %0d cycles before all transactions ended", cycles);
    $display("Error counts: value %0d, handshake %0d", valueErrors, handshakeErrors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* l2Cache.f */
+incdir+bench
hw/l2CachePkg.sv
hw/tagStateArray.sv
hw/wayLookup.sv
hw/lruPolicy.sv
hw/coherenceController.sv
hw/statCounters.sv
hw/l2CacheTop.sv
bench/l2CacheTb.sv

/* Bender.yml */
package:
  name: l2Cache

sources:
  - hw/l2CachePkg.sv
  - hw/tagStateArray.sv
  - hw/wayLookup.sv
  - hw/lruPolicy.sv
  - hw/coherenceController.sv
  - hw/statCounters.sv
  - hw/l2CacheTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/l2CacheTb.sv
